// File: verilog/executeParams.svh
// ######################################
// Widths, multiplier latency and RISC-V encodings shared by the
// execute stage and its testbench. Include it wherever a macro is used
// ######################################

`ifndef EXECUTE_PARAMS_SVH
`define EXECUTE_PARAMS_SVH

// Data path and register file geometry
`define WORD_WIDTH 32
`define NIBBLE_WIDTH 4
`define REG_ADDR_WIDTH 5

// Number of register stages between a MUL issue and its result
`define MUL_STAGES 6

// Major opcodes for the two arithmetic formats
`define OPCODE_OP 7'b0110011
`define OPCODE_OP_IMM 7'b0010011

// The funct3 field picks the operation family
`define FUNCT3_ADD_SUB 3'b000
`define FUNCT3_SLL 3'b001
`define FUNCT3_XOR 3'b100
`define FUNCT3_SRL 3'b101
`define FUNCT3_OR 3'b110
`define FUNCT3_AND 3'b111
`define FUNCT3_MUL 3'b000

// The funct7 field separates ADD from SUB and the M extension
`define FUNCT7_BASE 7'b0000000
`define FUNCT7_SUB 7'b0100000
`define FUNCT7_MULDIV 7'b0000001

`endif

// File: verilog/executePkg.sv
// ######################################
// Types shared by the execute stage: the operation code handed
// from the decoder to the ALU, and the two views of an instruction
// ######################################

`default_nettype none

`include "executeParams.svh"

package executePkg;

    // One entry per supported operation, MUL is routed to the multiplier
    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_MUL
    } aluOperation;

    // Register-register layout, most significant field first
    typedef struct packed {
        logic [6:0] funct7;
        logic [`REG_ADDR_WIDTH-1:0] rs2;
        logic [`REG_ADDR_WIDTH-1:0] rs1;
        logic [2:0] funct3;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [6:0] opcode;
    } rTypeFields;

    // Register-immediate layout, the immediate takes the funct7 and rs2 bits
    typedef struct packed {
        logic [11:0] immediate;
        logic [`REG_ADDR_WIDTH-1:0] rs1;
        logic [2:0] funct3;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [6:0] opcode;
    } iTypeFields;

    // Both views overlay the same 32 bits, so opcode, rd and funct3 line up
    typedef union packed {
        rTypeFields r;
        iTypeFields i;
    } instructionWord;

endpackage

`default_nettype wire

// File: verilog/instructionDecoder.sv
// ######################################
// Combinational decode of one issued instruction into an operation,
// a destination, the second ALU operand and an illegal flag
// ######################################

`default_nettype none

`include "executeParams.svh"

module instructionDecoder import executePkg::*; (
    input wire instructionWord instruction,
    input wire logic [`WORD_WIDTH-1:0] operandB,
    output aluOperation operation,
    output logic [`REG_ADDR_WIDTH-1:0] destination,
    output logic [`WORD_WIDTH-1:0] secondOperand,
    output logic isMultiply,
    output logic isIllegal
);

    logic [`WORD_WIDTH-1:0] signedImmediate;

    // Bit 11 of the immediate is copied into all upper bits
    assign signedImmediate = {{(`WORD_WIDTH-12){instruction.i.immediate[11]}},
                              instruction.i.immediate};

    // The rd field sits in the same place in both formats
    assign destination = instruction.r.rd;

    always_comb begin
        // Safe defaults so that an illegal word selects nothing harmful
        operation = OP_ADD;
        secondOperand = operandB;
        isMultiply = 1'b0;
        isIllegal = 1'b0;
        case (instruction.r.opcode)
            `OPCODE_OP: begin
                // Register form is fully identified by funct7 and funct3
                case ({instruction.r.funct7, instruction.r.funct3})
                    {`FUNCT7_BASE, `FUNCT3_ADD_SUB}: operation = OP_ADD;
                    {`FUNCT7_SUB, `FUNCT3_ADD_SUB}: operation = OP_SUB;
                    {`FUNCT7_BASE, `FUNCT3_AND}: operation = OP_AND;
                    {`FUNCT7_BASE, `FUNCT3_OR}: operation = OP_OR;
                    {`FUNCT7_BASE, `FUNCT3_XOR}: operation = OP_XOR;
                    {`FUNCT7_BASE, `FUNCT3_SLL}: operation = OP_SLL;
                    {`FUNCT7_BASE, `FUNCT3_SRL}: operation = OP_SRL;
                    {`FUNCT7_MULDIV, `FUNCT3_MUL}: begin
                        operation = OP_MUL;
                        isMultiply = 1'b1;
                    end
                    default: isIllegal = 1'b1;
                endcase
            end
            `OPCODE_OP_IMM: begin
                secondOperand = signedImmediate;
                // An immediate MUL is recognised through the R view of the same word,
                // which costs the ADDI immediates 32 to 63
                if (instruction.r.funct7 == `FUNCT7_MULDIV &&
                    instruction.i.funct3 == `FUNCT3_MUL) begin
                    isIllegal = 1'b1;
                end else begin
                    case (instruction.i.funct3)
                        `FUNCT3_ADD_SUB: operation = OP_ADD;
                        `FUNCT3_AND: operation = OP_AND;
                        `FUNCT3_OR: operation = OP_OR;
                        `FUNCT3_XOR: operation = OP_XOR;
                        `FUNCT3_SLL: operation = OP_SLL;
                        `FUNCT3_SRL: begin
                            // Only the logical shift exists, upper immediate bits must be zero
                            operation = OP_SRL;
                            isIllegal = (instruction.r.funct7 != `FUNCT7_BASE);
                        end
                        default: isIllegal = 1'b1;
                    endcase
                end
            end
            default: isIllegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/integerAlu.sv
// ######################################
// Single-cycle integer ALU. A start pulse yields a registered result
// with its destination and a valid pulse on the next clock edge
// ######################################

`default_nettype none

`include "executeParams.svh"

module integerAlu import executePkg::*; (
    input wire logic clock,
    input wire logic reset,
    input wire logic start,
    input wire aluOperation operation,
    input wire logic [`REG_ADDR_WIDTH-1:0] destination,
    input wire logic [`WORD_WIDTH-1:0] operandA,
    input wire logic [`WORD_WIDTH-1:0] operandB,
    output logic valid,
    output logic [`REG_ADDR_WIDTH-1:0] dest,
    output logic [`WORD_WIDTH-1:0] result
);

    // Shifts use only as many low bits as address a bit in the word
    localparam int SHIFT_WIDTH = $clog2(`WORD_WIDTH);

    logic [SHIFT_WIDTH-1:0] shiftAmount;
    logic [`WORD_WIDTH-1:0] nextResult;

    assign shiftAmount = operandB[SHIFT_WIDTH-1:0];

    always_comb begin
        case (operation)
            OP_ADD: nextResult = operandA + operandB;
            OP_SUB: nextResult = operandA - operandB;
            OP_AND: nextResult = operandA & operandB;
            OP_OR: nextResult = operandA | operandB;
            OP_XOR: nextResult = operandA ^ operandB;
            OP_SLL: nextResult = operandA << shiftAmount;
            OP_SRL: nextResult = operandA >> shiftAmount;
            // MUL never reaches this unit, the top level sends it to the multiplier
            default: nextResult = '0;
        endcase
    end

    // The valid bit is the only control state here
    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= 1'b0;
        end else begin
            valid <= start;
        end
    end

    // Payload is captured only when an operation starts and holds otherwise
    always_ff @(posedge clock) begin
        if (start) begin
            dest <= destination;
            result <= nextResult;
        end
    end

endmodule

`default_nettype wire

// File: verilog/pipelinedMultiplier.sv
// ######################################
// Six-stage pipelined 32-bit multiplier built from 4-by-4 nibble products.
// Returns the low word of the product with its destination tag
// ######################################

`default_nettype none

`include "executeParams.svh"

module pipelinedMultiplier (
    input wire logic clock,
    input wire logic reset,
    input wire logic start,
    input wire logic [`REG_ADDR_WIDTH-1:0] destination,
    input wire logic [`WORD_WIDTH-1:0] multiplicand,
    input wire logic [`WORD_WIDTH-1:0] multiplier,
    output logic valid,
    output logic [`REG_ADDR_WIDTH-1:0] dest,
    output logic [`WORD_WIDTH-1:0] product
);

    localparam int NIBBLES = `WORD_WIDTH / `NIBBLE_WIDTH;
    localparam int PRODUCTS = NIBBLES * NIBBLES;

    // Operand registers of stage 1
    logic [`WORD_WIDTH-1:0] multiplicandReg;
    logic [`WORD_WIDTH-1:0] multiplierReg;

    // Partial sums of stages 2 to 5, each half the size of the one before
    logic [`WORD_WIDTH-1:0] partialProduct1 [PRODUCTS];
    logic [`WORD_WIDTH-1:0] partialProduct2 [PRODUCTS/2];
    logic [`WORD_WIDTH-1:0] partialProduct3 [PRODUCTS/4];
    logic [`WORD_WIDTH-1:0] partialProduct4 [PRODUCTS/8];

    // Sum of the last eight terms, registered as the product in stage 6
    logic [`WORD_WIDTH-1:0] finalSum;

    // Valid bits and destination tags travel beside the data, index 1 is stage 1
    logic [`MUL_STAGES:1] stageValid;
    logic [`REG_ADDR_WIDTH-1:0] stageDest [`MUL_STAGES:1];

    // Nibble product widened to a word and moved to its weight.
    // Bits shifted past the top are dropped, which keeps the sum modulo 2^32
    function automatic logic [`WORD_WIDTH-1:0] shiftedNibbleProduct(
        input logic [`NIBBLE_WIDTH-1:0] a,
        input logic [`NIBBLE_WIDTH-1:0] b,
        input int weight
    );
        logic [`WORD_WIDTH-1:0] wideProduct;
        wideProduct = `WORD_WIDTH'(a) * `WORD_WIDTH'(b);
        return wideProduct << (`NIBBLE_WIDTH * weight);
    endfunction

    // Stage 1 takes the operands as issued
    always_ff @(posedge clock) begin
        multiplicandReg <= multiplicand;
        multiplierReg <= multiplier;
    end

    // Stage 2 forms every nibble pair, nibble i of the multiplicand
    // against nibble j of the multiplier lands at index i*NIBBLES+j
    always_ff @(posedge clock) begin
        for (int i = 0; i < NIBBLES; i++) begin
            for (int j = 0; j < NIBBLES; j++) begin
                partialProduct1[i*NIBBLES + j] <= shiftedNibbleProduct(
                    multiplicandReg[i*`NIBBLE_WIDTH +: `NIBBLE_WIDTH],
                    multiplierReg[j*`NIBBLE_WIDTH +: `NIBBLE_WIDTH],
                    i + j);
            end
        end
    end

    // Stage 3 reduces 64 terms to 32
    always_ff @(posedge clock) begin
        for (int k = 0; k < PRODUCTS/2; k++) begin
            partialProduct2[k] <= partialProduct1[2*k] + partialProduct1[2*k + 1];
        end
    end

    // Stage 4 reduces 32 terms to 16
    always_ff @(posedge clock) begin
        for (int k = 0; k < PRODUCTS/4; k++) begin
            partialProduct3[k] <= partialProduct2[2*k] + partialProduct2[2*k + 1];
        end
    end

    // Stage 5 reduces 16 terms to 8
    always_ff @(posedge clock) begin
        for (int k = 0; k < PRODUCTS/8; k++) begin
            partialProduct4[k] <= partialProduct3[2*k] + partialProduct3[2*k + 1];
        end
    end

    // The remaining eight terms are added in one adder chain
    always_comb begin
        finalSum = '0;
        for (int k = 0; k < PRODUCTS/8; k++) begin
            finalSum = finalSum + partialProduct4[k];
        end
    end

    // Stage 6 registers the finished low word
    always_ff @(posedge clock) begin
        product <= finalSum;
    end

    // Valid chain is cleared by reset so no stale product can leave
    always_ff @(posedge clock) begin
        if (reset) begin
            stageValid <= '0;
        end else begin
            stageValid <= {stageValid[`MUL_STAGES-1:1], start};
        end
    end

    // Tags shift every cycle in step with the data stages
    always_ff @(posedge clock) begin
        stageDest[1] <= destination;
        for (int s = 2; s <= `MUL_STAGES; s++) begin
            stageDest[s] <= stageDest[s-1];
        end
    end

    assign valid = stageValid[`MUL_STAGES];
    assign dest = stageDest[`MUL_STAGES];

endmodule

`default_nettype wire

// File: verilog/executeUnit.sv
// ######################################
// Integer execute stage. Decodes one issued instruction per cycle and
// sends it to the ALU or to the pipelined multiplier
// ######################################

`default_nettype none

`include "executeParams.svh"

module executeUnit import executePkg::*; (
    input wire logic clock,
    input wire logic reset,
    input wire logic issue,
    input wire instructionWord instruction,
    input wire logic [`WORD_WIDTH-1:0] operandA,
    input wire logic [`WORD_WIDTH-1:0] operandB,
    output logic aluValid,
    output logic [`REG_ADDR_WIDTH-1:0] aluDest,
    output logic [`WORD_WIDTH-1:0] aluResult,
    output logic mulValid,
    output logic [`REG_ADDR_WIDTH-1:0] mulDest,
    output logic [`WORD_WIDTH-1:0] mulResult,
    output logic illegal
);

    aluOperation operation;
    logic [`REG_ADDR_WIDTH-1:0] destination;
    logic [`WORD_WIDTH-1:0] secondOperand;
    logic isMultiply;
    logic isIllegal;
    logic aluStart;
    logic mulStart;

    instructionDecoder decoder (
        .instruction(instruction),
        .operandB(operandB),
        .operation(operation),
        .destination(destination),
        .secondOperand(secondOperand),
        .isMultiply(isMultiply),
        .isIllegal(isIllegal)
    );

    // Decoder outputs only count while an instruction is issued
    assign aluStart = issue && !isIllegal && !isMultiply;
    assign mulStart = issue && isMultiply;

    integerAlu alu (
        .clock(clock),
        .reset(reset),
        .start(aluStart),
        .operation(operation),
        .destination(destination),
        .operandA(operandA),
        .operandB(secondOperand),
        .valid(aluValid),
        .dest(aluDest),
        .result(aluResult)
    );

    // The multiplier always takes rs2, an immediate MUL never gets here
    pipelinedMultiplier multiplierUnit (
        .clock(clock),
        .reset(reset),
        .start(mulStart),
        .destination(destination),
        .multiplicand(operandA),
        .multiplier(operandB),
        .valid(mulValid),
        .dest(mulDest),
        .product(mulResult)
    );

    // Registered so that illegal lines up with the ALU result cycle
    always_ff @(posedge clock) begin
        if (reset) begin
            illegal <= 1'b0;
        end else begin
            illegal <= issue && isIllegal;
        end
    end

endmodule

`default_nettype wire

// File: testbench/executeUnitSva.sv
// ######################################
// Protocol checks bound into the execute stage. Quiet outputs around
// reset, fixed multiplier latency and exclusive ALU and illegal pulses
// ######################################

`default_nettype none

`include "executeParams.svh"

module executeUnitSva (
    input wire logic clock,
    input wire logic reset,
    input wire logic mulStart,
    input wire logic aluValid,
    input wire logic mulValid,
    input wire logic illegal
);

    // High from the second edge on, before that the outputs are still unknown
    logic clocked;

    initial clocked = 1'b0;

    always @(posedge clock) begin
        clocked <= 1'b1;
    end

    // Nothing leaves the stage while reset is applied or on the edge right after it
    quietAroundReset: assert property (@(posedge clock)
        clocked && $past(reset) |-> !aluValid && !mulValid && !illegal)
        else $error("Execute unit output valid during reset or just after it");

    // A MUL accepted by the multiplier comes out exactly MUL_STAGES cycles later
    mulLatency: assert property (@(posedge clock) disable iff (reset)
        mulStart |-> ##(`MUL_STAGES) mulValid)
        else $error("Multiplier result missing MUL_STAGES cycles after a MUL issue");

    // And no product appears without a MUL that far back
    mulHasSource: assert property (@(posedge clock) disable iff (reset)
        mulValid |-> $past(mulStart, `MUL_STAGES))
        else $error("Multiplier result with no matching MUL issue");

    // One instruction is either executed or rejected, never both
    aluIllegalExclusive: assert property (@(posedge clock)
        clocked |-> !(aluValid && illegal))
        else $error("ALU result and illegal flag raised in the same cycle");

endmodule

bind executeUnit executeUnitSva protocolChecks (
    .clock(clock),
    .reset(reset),
    .mulStart(mulStart),
    .aluValid(aluValid),
    .mulValid(mulValid),
    .illegal(illegal)
);

`default_nettype wire

// File: testbench/executeUnitTb.sv
// ######################################
// Random testbench for the execute stage. Issues legal and illegal
// instructions from a fixed seed and checks every result port against a model
// ######################################

`default_nettype none

`include "executeParams.svh"

module executeUnitTb import executePkg::*; ();

    localparam int INSTRUCTION_COUNT = 2000;
    localparam int CYCLE_LIMIT = 10 * INSTRUCTION_COUNT;
    localparam int DRAIN_LIMIT = 4 * `MUL_STAGES;
    localparam int ALU_ERRORS = 0;
    localparam int MUL_ERRORS = 1;
    localparam int ILLEGAL_ERRORS = 2;
    localparam int LOST_ERRORS = 3;

    logic clock;
    logic reset;
    logic issue;
    instructionWord instruction;
    logic [`WORD_WIDTH-1:0] operandA;
    logic [`WORD_WIDTH-1:0] operandB;
    logic aluValid;
    logic [`REG_ADDR_WIDTH-1:0] aluDest;
    logic [`WORD_WIDTH-1:0] aluResult;
    logic mulValid;
    logic [`REG_ADDR_WIDTH-1:0] mulDest;
    logic [`WORD_WIDTH-1:0] mulResult;
    logic illegal;

    integer seed;
    int cycle;
    int issuedCount;
    int missingResults;
    int errorCount [4];

    // ALU and illegal expectations wait one cycle in the pending slot
    logic pendingAluValid;
    logic pendingIllegal;
    logic [`REG_ADDR_WIDTH-1:0] pendingDest;
    logic [`WORD_WIDTH-1:0] pendingResult;
    logic expectedAluValid;
    logic expectedIllegal;
    logic [`REG_ADDR_WIDTH-1:0] expectedDest;
    logic [`WORD_WIDTH-1:0] expectedResult;

    // Multiplies in flight with the cycle in which each result is due
    int mulDueQueue [$];
    logic [`REG_ADDR_WIDTH-1:0] mulDestQueue [$];
    logic [`WORD_WIDTH-1:0] mulValueQueue [$];

    executeUnit dut_i (
        .clock(clock),
        .reset(reset),
        .issue(issue),
        .instruction(instruction),
        .operandA(operandA),
        .operandB(operandB),
        .aluValid(aluValid),
        .aluDest(aluDest),
        .aluResult(aluResult),
        .mulValid(mulValid),
        .mulDest(mulDest),
        .mulResult(mulResult),
        .illegal(illegal)
    );

    always #10 clock = ~clock;

    task automatic randomOperand(output logic [`WORD_WIDTH-1:0] value);
        logic [31:0] pick;
        pick = $random(seed);
        // Corner values come up in about three draws out of eight
        case (pick[2:0])
            3'd0: value = '0;
            3'd1: value = '1;
            3'd2: value = 32'h8000_0000;
            default: value = $random(seed);
        endcase
    endtask

    task automatic randomInstruction(input logic forceMul, output instructionWord word);
        logic [31:0] pick;
        logic [3:0] kind;
        pick = $random(seed);
        word = $random(seed);
        kind = forceMul ? 4'd5 : pick[3:0];
        if (kind <= 4'd7) begin
            // Kinds 5 to 7 build a register MUL and kinds 0 to 4 a base ALU code
            word.r.opcode = `OPCODE_OP;
            word.r.funct7 = (kind >= 4'd5) ? `FUNCT7_MULDIV : `FUNCT7_BASE;
            word.r.funct3 = (kind >= 4'd5) ? `FUNCT3_MUL : pick[6:4];
            if (kind < 4'd5 && pick[6:4] == `FUNCT3_ADD_SUB && pick[7]) begin
                word.r.funct7 = `FUNCT7_SUB;
            end
        end else if (kind <= 4'd13) begin
            // Kind 13 tries the immediate MUL that must be rejected
            word.i.opcode = `OPCODE_OP_IMM;
            if (kind == 4'd13) begin
                word.r.funct7 = `FUNCT7_MULDIV;
                word.i.funct3 = `FUNCT3_MUL;
            end else if (pick[8] &&
                         (word.i.funct3 == `FUNCT3_SLL || word.i.funct3 == `FUNCT3_SRL)) begin
                // Shift immediates mostly keep their upper field clear
                word.r.funct7 = `FUNCT7_BASE;
            end
        end else if (kind == 4'd14) begin
            word.r.opcode = `OPCODE_OP;
        end
        // Kind 15 keeps the whole word random
    endtask

    task automatic modelInstruction(
        input instructionWord word,
        input logic [`WORD_WIDTH-1:0] a,
        input logic [`WORD_WIDTH-1:0] b,
        output logic toAlu,
        output logic toMul,
        output logic isBad,
        output logic [`WORD_WIDTH-1:0] value
    );
        logic [`WORD_WIDTH-1:0] second;
        logic [6:0] upper;
        logic [2:0] funct3;
        logic supported;
        logic isSub;
        // funct3 and the top seven bits sit at the same place in both formats
        funct3 = word.r.funct3;
        upper = word.r.funct7;
        second = b;
        toMul = 1'b0;
        isSub = 1'b0;
        supported = 1'b1;
        value = '0;
        if (word.r.opcode == `OPCODE_OP) begin
            if (upper == `FUNCT7_MULDIV && funct3 == `FUNCT3_MUL) begin
                toMul = 1'b1;
                value = a * b;
            end else if (upper == `FUNCT7_SUB) begin
                supported = (funct3 == `FUNCT3_ADD_SUB);
                isSub = 1'b1;
            end else begin
                supported = (upper == `FUNCT7_BASE);
            end
        end else if (word.r.opcode == `OPCODE_OP_IMM) begin
            second = {{(`WORD_WIDTH-12){word.i.immediate[11]}}, word.i.immediate};
            // Immediates 32 to 63 under funct3 000 read as an immediate MUL
            supported = !(upper == `FUNCT7_MULDIV && funct3 == `FUNCT3_MUL);
            if (funct3 == `FUNCT3_SRL && upper != `FUNCT7_BASE) begin
                supported = 1'b0;
            end
        end else begin
            supported = 1'b0;
        end
        if (!toMul) begin
            case (funct3)
                `FUNCT3_ADD_SUB: value = isSub ? a - second : a + second;
                `FUNCT3_SLL: value = a << second[4:0];
                `FUNCT3_XOR: value = a ^ second;
                `FUNCT3_SRL: value = a >> second[4:0];
                `FUNCT3_OR: value = a | second;
                `FUNCT3_AND: value = a & second;
                default: supported = 1'b0;
            endcase
        end
        isBad = !supported;
        toAlu = supported && !toMul;
    endtask

    // Moves last cycle's expectation into place for the check at the falling edge
    task automatic shiftSlot();
        expectedAluValid = pendingAluValid;
        expectedIllegal = pendingIllegal;
        expectedDest = pendingDest;
        expectedResult = pendingResult;
        pendingAluValid = 1'b0;
        pendingIllegal = 1'b0;
    endtask

    task automatic prepareStimulus(
        input logic allowIssue,
        input logic forceMul,
        output logic doIssue,
        output instructionWord word,
        output logic [`WORD_WIDTH-1:0] a,
        output logic [`WORD_WIDTH-1:0] b
    );
        logic [31:0] pick;
        logic toAlu;
        logic toMul;
        logic isBad;
        logic [`WORD_WIDTH-1:0] value;
        shiftSlot();
        pick = $random(seed);
        // About 70 percent of cycles carry an instruction while a MUL burst fills every cycle
        doIssue = allowIssue && (forceMul || pick[7:0] < 8'd179);
        randomInstruction(forceMul, word);
        randomOperand(a);
        randomOperand(b);
        modelInstruction(word, a, b, toAlu, toMul, isBad, value);
        pendingAluValid = doIssue && toAlu;
        pendingIllegal = doIssue && isBad;
        pendingDest = word.r.rd;
        pendingResult = value;
        if (doIssue && toMul) begin
            mulDueQueue.push_back(cycle + `MUL_STAGES);
            mulDestQueue.push_back(word.r.rd);
            mulValueQueue.push_back(value);
        end
        if (doIssue) begin
            issuedCount++;
        end
    endtask

    task automatic compareValue(
        input string signalName,
        input logic [`WORD_WIDTH-1:0] expected,
        input logic [`WORD_WIDTH-1:0] actual,
        input int category
    );
        assert (actual === expected) else begin
            $display("[ERROR] time %0t %s expected %0h actual %0h",
                     $time, signalName, expected, actual);
            errorCount[category]++;
        end
    endtask

    task automatic checkOutputs();
        logic mulDue;
        mulDue = mulDueQueue.size() != 0 && mulDueQueue[0] == cycle;
        compareValue("aluValid", `WORD_WIDTH'(expectedAluValid), `WORD_WIDTH'(aluValid),
                     ALU_ERRORS);
        if (expectedAluValid && aluValid) begin
            compareValue("aluDest", `WORD_WIDTH'(expectedDest), `WORD_WIDTH'(aluDest),
                         ALU_ERRORS);
            compareValue("aluResult", expectedResult, aluResult, ALU_ERRORS);
        end
        compareValue("illegal", `WORD_WIDTH'(expectedIllegal), `WORD_WIDTH'(illegal),
                     ILLEGAL_ERRORS);
        compareValue("mulValid", `WORD_WIDTH'(mulDue), `WORD_WIDTH'(mulValid), MUL_ERRORS);
        if (mulDue) begin
            if (mulValid) begin
                compareValue("mulDest", `WORD_WIDTH'(mulDestQueue[0]), `WORD_WIDTH'(mulDest),
                             MUL_ERRORS);
                compareValue("mulResult", mulValueQueue[0], mulResult, MUL_ERRORS);
            end else begin
                // A product that fails to show up in its due cycle is lost for good
                missingResults++;
            end
            void'(mulDueQueue.pop_front());
            void'(mulDestQueue.pop_front());
            void'(mulValueQueue.pop_front());
        end
    endtask

    initial begin
        logic doIssue;
        logic forceMul;
        instructionWord word;
        logic [`WORD_WIDTH-1:0] a;
        logic [`WORD_WIDTH-1:0] b;
        int drainCycles;
        seed = 53;
        clock = 1'b0;
        reset = 1'b1;
        issue = 1'b0;
        instruction = '0;
        operandA = '0;
        operandB = '0;
        cycle = 0;
        issuedCount = 0;
        missingResults = 0;
        errorCount = '{default: 0};
        pendingAluValid = 1'b0;
        pendingIllegal = 1'b0;
        pendingDest = '0;
        pendingResult = '0;
        shiftSlot();
        // Reset spans five rising edges and the outputs must be low after each one
        repeat (5) begin
            @(posedge clock);
            cycle++;
            if (cycle == 5) begin
                reset <= 1'b0;
            end
            @(negedge clock);
            checkOutputs();
        end
        // Three idle cycles come first and then random issue with a MUL burst every 250
        while (issuedCount < INSTRUCTION_COUNT && cycle < CYCLE_LIMIT) begin
            @(posedge clock);
            cycle++;
            forceMul = (issuedCount % 250) >= 242;
            prepareStimulus(cycle > 8, forceMul, doIssue, word, a, b);
            issue <= doIssue;
            instruction <= word;
            operandA <= a;
            operandB <= b;
            @(negedge clock);
            checkOutputs();
        end
        assert (issuedCount == INSTRUCTION_COUNT) else begin
            $display("Stimulus loop timed out after %0d cycles with %0d instructions issued",
                     cycle, issuedCount);
            errorCount[LOST_ERRORS]++;
        end
        // Let the last ALU slot and every multiply in flight come out
        drainCycles = 0;
        while ((drainCycles < 2 || mulDueQueue.size() != 0) && drainCycles < DRAIN_LIMIT) begin
            @(posedge clock);
            cycle++;
            drainCycles++;
            shiftSlot();
            issue <= 1'b0;
            @(negedge clock);
            checkOutputs();
        end
        assert (missingResults == 0 && mulDueQueue.size() == 0) else begin
            $display("%0d multiplier results never arrived",
                     missingResults + mulDueQueue.size());
            errorCount[LOST_ERRORS]++;
        end
        $display("Error counts: alu %0d, multiplier %0d, illegal %0d, lost or timeout %0d",
                 errorCount[ALU_ERRORS], errorCount[MUL_ERRORS],
                 errorCount[ILLEGAL_ERRORS], errorCount[LOST_ERRORS]);
        if (errorCount.sum() == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+verilog
verilog/executePkg.sv
verilog/instructionDecoder.sv
verilog/integerAlu.sv
verilog/pipelinedMultiplier.sv
verilog/executeUnit.sv
testbench/executeUnitSva.sv
testbench/executeUnitTb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the execute stage testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=simulation.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module executeUnitTb -Mdir "$BUILD_DIR" -o executeUnitSim \
    -f compile.f
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
    echo "Verilator build failed with status $buildStatus"
    exit 1
fi

"./$BUILD_DIR/executeUnitSim" > "$LOG_FILE" 2>&1
simStatus=$?
cat "$LOG_FILE"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "TEST PASSED" "$LOG_FILE"; then
    exit 0
fi
echo "Pass message not found in $LOG_FILE"
exit 1
